//--- Makefile
VERILATOR ?= verilator
TOP       ?= ahb_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= >>> PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# status comes from the search for the pass line
sim: build
	@out="$$($(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- design/ahb_defs.svh
`ifndef AHB_DEFS_SVH
`define AHB_DEFS_SVH

//////////////////////////////
// bus widths

// HADDR and request address
`define AHB_ADDR_W 32

// HWDATA, HRDATA and request data
`define AHB_DATA_W 32

//////////////////////////////
// slave memory

`define AHB_MEM_WORDS 256   // 1 KB of word storage, byte addr 0..1023

// wait cycles before each data phase completes
`define AHB_WAIT_STATES 2

`endif

//--- design/ahb_master.sv
`timescale 1ns/100ps
`default_nettype none

`include "ahb_defs.svh"

// one word transfer at a time, single NONSEQ, no pipelining
module ahb_master (
  input  logic              CLK,
  input  logic              nRST,
  input  ahb_pkg::mem_req_t mem_req,
  output ahb_pkg::mem_rsp_t mem_rsp,
  output ahb_pkg::ahb_req_t bus_req,
  input  ahb_pkg::ahb_rsp_t bus_rsp
);

  ahb_pkg::master_state_t state, next_state;

  logic                   start;       // request accepted this cycle
  logic                   data_end;    // data phase completes this cycle
  logic                   bus_active;  // address or data phase

  logic                   write_q;     // 1 = write transfer
  logic                   err_q;
  logic [`AHB_ADDR_W-1:0] addr_q;
  logic [`AHB_DATA_W-1:0] wdata_q;
  logic [`AHB_DATA_W-1:0] rdata_q;

  // requests are only looked at in idle
  assign start      = (state == ahb_pkg::M_IDLE) && (mem_req.ren || mem_req.wen);
  assign data_end   = (state == ahb_pkg::M_DATA) && bus_rsp.hready;
  assign bus_active = (state == ahb_pkg::M_ADDR) || (state == ahb_pkg::M_DATA);

  //////////////////////////////
  // state register

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= ahb_pkg::M_IDLE;
    end else begin
      state <= next_state;
    end
  end

  //////////////////////////////
  // next state

  always_comb begin
    next_state = state;   // hold by default
    case (state)
      ahb_pkg::M_IDLE: begin
        if (start) begin
          next_state = ahb_pkg::M_ADDR;
        end
      end
      ahb_pkg::M_ADDR: begin
        // slave is always ready in idle, never stretched
        next_state = ahb_pkg::M_DATA;
      end
      ahb_pkg::M_DATA: begin
        if (data_end) begin
          next_state = ahb_pkg::M_DONE;  // okay or 2nd error cycle
        end
      end
      ahb_pkg::M_DONE: begin
        next_state = ahb_pkg::M_IDLE;    // request lines ignored here
      end
      default: begin
        next_state = ahb_pkg::M_IDLE;
      end
    endcase
  end

  //////////////////////////////
  // transfer control

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      write_q <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      if (start) begin
        write_q <= ~mem_req.ren;   // ren wins if both high
        err_q   <= 1'b0;
      end else if (data_end) begin
        // hresp only meaningful once hready is back high
        err_q <= (bus_rsp.hresp == ahb_pkg::ERROR);
      end
    end
  end

  // address, write data and read data
  always_ff @(posedge CLK) begin
    if (start) begin
      addr_q  <= mem_req.addr;    // later changes on the port ignored
      wdata_q <= mem_req.wdata;
    end
    if (data_end && !write_q) begin
      rdata_q <= bus_rsp.hrdata;
    end
  end

  //////////////////////////////
  // bus side

  // HBURST is SINGLE, HPROT a plain data access and HMASTLOCK low,
  // tied off here since the slave has no use for them
  always_comb begin
    bus_req.htrans = (state == ahb_pkg::M_ADDR) ? ahb_pkg::NONSEQ : ahb_pkg::IDLE;
    bus_req.hwrite = write_q & bus_active;   // held through data phase
    bus_req.hsize  = ahb_pkg::WORD;          // word only
    bus_req.haddr  = addr_q;
    bus_req.hwdata = wdata_q;                // sampled by slave in data phase
  end

  //////////////////////////////
  // requester side

  always_comb begin
    mem_rsp.busy  = bus_active;
    mem_rsp.done  = (state == ahb_pkg::M_DONE);
    mem_rsp.err   = err_q & (state == ahb_pkg::M_DONE);
    mem_rsp.rdata = rdata_q;
  end

endmodule

`default_nettype wire

//--- design/ahb_pkg.sv
`default_nettype none

`include "ahb_defs.svh"

package ahb_pkg;

  //////////////////////////////
  // AHB-Lite encodings

  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,   // never issued here
    NONSEQ = 2'b10,
    SEQ    = 2'b11    // bursts only
  } htrans_t;

  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_t;

  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsize_t;

  //////////////////////////////
  // bus bundles

  // master to slave
  typedef struct packed {
    htrans_t                htrans;
    logic                   hwrite;
    hsize_t                 hsize;
    logic [`AHB_ADDR_W-1:0] haddr;
    logic [`AHB_DATA_W-1:0] hwdata;   // data phase
  } ahb_req_t;

  // slave to master
  typedef struct packed {
    logic                   hready;
    hresp_t                 hresp;
    logic [`AHB_DATA_W-1:0] hrdata;
  } ahb_rsp_t;

  //////////////////////////////
  // requester side

  typedef struct packed {
    logic                   ren;     // level, held until done
    logic                   wen;     // level, held until done
    logic [`AHB_ADDR_W-1:0] addr;
    logic [`AHB_DATA_W-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic                   busy;    // transfer in flight
    logic                   done;    // single cycle pulse
    logic                   err;     // qualified by done
    logic [`AHB_DATA_W-1:0] rdata;   // qualified by done on reads
  } mem_rsp_t;

  //////////////////////////////
  // FSM states

  typedef enum logic [1:0] {
    M_IDLE,
    M_ADDR,   // address phase, NONSEQ on the bus
    M_DATA,   // data phase, stretched by hready
    M_DONE    // done pulse to requester
  } master_state_t;

  typedef enum logic [2:0] {
    S_IDLE,
    S_WAIT,   // counting wait states
    S_DATA,   // okay completion
    S_ERR1,   // error, hready low
    S_ERR2    // error, hready high
  } slave_state_t;

endpackage

`default_nettype wire

//--- design/ahb_ram_slave.sv
`timescale 1ns/100ps
`default_nettype none

`include "ahb_defs.svh"

// word RAM behind AHB-Lite, fixed wait states, error on bad address
module ahb_ram_slave #(
  parameter int WAIT_STATES = `AHB_WAIT_STATES
) (
  input  logic              CLK,
  input  logic              nRST,
  input  ahb_pkg::ahb_req_t bus_req,
  output ahb_pkg::ahb_rsp_t bus_rsp
);

  localparam int IDX_W = $clog2(`AHB_MEM_WORDS);
  localparam int CNT_W = (WAIT_STATES > 1) ? $clog2(WAIT_STATES) : 1;
  localparam logic [`AHB_ADDR_W-1:0] ADDR_LIMIT = `AHB_MEM_WORDS * 4;   // first bad byte

  ahb_pkg::slave_state_t state, next_state;

  logic                   hready;
  logic                   addr_phase;   // NONSEQ sampled this cycle
  logic                   addr_bad;     // out of range or misaligned
  logic [IDX_W-1:0]       cur_idx;
  logic [CNT_W-1:0]       wait_cnt;     // wait cycles left minus one
  logic                   hwrite_q;
  logic                   bad_q;
  logic [IDX_W-1:0]       idx_q;
  logic [`AHB_DATA_W-1:0] rdata_q;
  logic [`AHB_DATA_W-1:0] mem [`AHB_MEM_WORDS];

  assign addr_phase = (state == ahb_pkg::S_IDLE) &&
                      (bus_req.htrans == ahb_pkg::NONSEQ) && hready;
  assign addr_bad   = (bus_req.haddr >= ADDR_LIMIT) || (bus_req.haddr[1:0] != 2'b00);

  // live address in idle, registered one afterwards
  assign cur_idx = (state == ahb_pkg::S_IDLE) ? bus_req.haddr[IDX_W+1:2] : idx_q;

  //////////////////////////////
  // next state

  always_comb begin
    next_state = state;
    case (state)
      ahb_pkg::S_IDLE: begin
        if (addr_phase) begin
          if (WAIT_STATES != 0) begin
            next_state = ahb_pkg::S_WAIT;
          end else if (addr_bad) begin
            next_state = ahb_pkg::S_ERR1;
          end else begin
            next_state = ahb_pkg::S_DATA;
          end
        end
      end
      ahb_pkg::S_WAIT: begin
        if (wait_cnt == '0) begin
          next_state = bad_q ? ahb_pkg::S_ERR1 : ahb_pkg::S_DATA;
        end
      end
      ahb_pkg::S_DATA: next_state = ahb_pkg::S_IDLE;
      ahb_pkg::S_ERR1: next_state = ahb_pkg::S_ERR2;   // two cycle error response
      ahb_pkg::S_ERR2: next_state = ahb_pkg::S_IDLE;
      default:         next_state = ahb_pkg::S_IDLE;
    endcase
  end

  //////////////////////////////
  // control registers

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state    <= ahb_pkg::S_IDLE;
      wait_cnt <= '0;
      hwrite_q <= 1'b0;
      bad_q    <= 1'b0;
    end else begin
      state <= next_state;
      if (addr_phase) begin
        hwrite_q <= bus_req.hwrite;
        bad_q    <= addr_bad;
        wait_cnt <= (WAIT_STATES > 0) ? CNT_W'(WAIT_STATES - 1) : '0;
      end else if (state == ahb_pkg::S_WAIT && wait_cnt != '0) begin
        wait_cnt <= wait_cnt - 1'b1;
      end
    end
  end

  //////////////////////////////
  // storage

  always_ff @(posedge CLK) begin
    if (addr_phase) begin
      idx_q <= cur_idx;
    end
    if (state == ahb_pkg::S_DATA && hwrite_q) begin
      mem[idx_q] <= bus_req.hwdata;   // write data valid in data phase
    end
    // fetch on entry to the completing cycle, harmless on writes
    if (next_state == ahb_pkg::S_DATA) begin
      rdata_q <= mem[cur_idx];
    end
  end

  //////////////////////////////
  // response

  assign hready = (state == ahb_pkg::S_IDLE) ||
                  (state == ahb_pkg::S_DATA) ||
                  (state == ahb_pkg::S_ERR2);

  always_comb begin
    bus_rsp.hready = hready;
    bus_rsp.hresp  = (state == ahb_pkg::S_ERR1 || state == ahb_pkg::S_ERR2) ?
                     ahb_pkg::ERROR : ahb_pkg::OKAY;
    bus_rsp.hrdata = rdata_q;   // master samples only on okay reads
  end

endmodule

`default_nettype wire

//--- design/ahb_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

// request port -> AHB-Lite master -> RAM slave
module ahb_subsystem (
  input  logic              CLK,
  input  logic              nRST,
  input  ahb_pkg::mem_req_t mem_req,
  output ahb_pkg::mem_rsp_t mem_rsp
);

  //////////////////////////////
  // internal bus

  ahb_pkg::ahb_req_t bus_req;   // master to slave
  ahb_pkg::ahb_rsp_t bus_rsp;   // slave to master

  //////////////////////////////
  // master

  ahb_master ahb_master_inst (
    .CLK     (CLK),
    .nRST    (nRST),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp)
  );

  //////////////////////////////
  // slave, default wait states

  ahb_ram_slave ahb_ram_slave_inst (
    .CLK     (CLK),
    .nRST    (nRST),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp)
  );

endmodule

`default_nettype wire

//--- tb.f
+incdir+design
design/ahb_pkg.sv
design/ahb_master.sv
design/ahb_ram_slave.sv
design/ahb_subsystem.sv
testbench/ahb_assert.sv
testbench/ahb_tb.sv

//--- testbench/ahb_assert.sv
`timescale 1ns/100ps
`default_nettype none

// bus protocol checks on the internal AHB-Lite link
module ahb_assert (
  input logic              CLK,
  input logic              nRST,
  input ahb_pkg::ahb_req_t bus_req,
  input ahb_pkg::ahb_rsp_t bus_rsp,
  input ahb_pkg::mem_rsp_t mem_rsp
);

  int unsigned fail_cnt = 0;   // failed checks so far

  // single transfers only, never BUSY or SEQ
  htrans_legal: assert property (@(posedge CLK) disable iff (!nRST)
    (bus_req.htrans == ahb_pkg::IDLE) || (bus_req.htrans == ahb_pkg::NONSEQ))
    else begin
      fail_cnt++;
      $error("htrans is neither IDLE nor NONSEQ");
    end

  // master holds the transfer while the slave stretches it
  hold_on_wait: assert property (@(posedge CLK) disable iff (!nRST)
    !bus_rsp.hready |=> $stable(bus_req.haddr) && $stable(bus_req.hwrite) &&
                        $stable(bus_req.hwdata))
    else begin
      fail_cnt++;
      $error("haddr, hwrite or hwdata changed during a wait state");
    end

  // two cycle ERROR, low hready first
  err_two_cycle: assert property (@(posedge CLK) disable iff (!nRST)
    (bus_rsp.hresp == ahb_pkg::ERROR && bus_rsp.hready) |->
      $past(bus_rsp.hresp == ahb_pkg::ERROR && !bus_rsp.hready))
    else begin
      fail_cnt++;
      $error("ERROR with hready high not preceded by ERROR with hready low");
    end

  done_pulse: assert property (@(posedge CLK) disable iff (!nRST)
    mem_rsp.done |=> !mem_rsp.done)   // one cycle only
    else begin
      fail_cnt++;
      $error("done high for two consecutive cycles");
    end

endmodule

bind ahb_subsystem ahb_assert ahb_assert_inst (
  .CLK     (CLK),
  .nRST    (nRST),
  .bus_req (bus_req),
  .bus_rsp (bus_rsp),
  .mem_rsp (mem_rsp)
);

`default_nettype wire

//--- testbench/ahb_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "ahb_defs.svh"

module ahb_tb;

  localparam int W            = `AHB_WAIT_STATES;
  localparam int IDX_W        = $clog2(`AHB_MEM_WORDS);
  localparam int DONE_TIMEOUT = 64;   // cycles per transfer
  localparam int RAND_OPS     = 40;

  // one table row, name kept alongside in name_q
  typedef struct packed {
    logic                   is_write;
    logic                   held;        // watch for a second done afterwards
    logic [`AHB_ADDR_W-1:0] addr;
    logic [`AHB_DATA_W-1:0] wdata;
    logic [`AHB_DATA_W-1:0] exp_rdata;   // reads with err low only
    logic                   exp_err;
  } vec_t;

  logic              CLK;
  logic              nRST;
  ahb_pkg::mem_req_t mem_req;
  ahb_pkg::mem_rsp_t mem_rsp;

  vec_t                   vec_q [$];
  string                  name_q [$];
  logic [`AHB_DATA_W-1:0] model_mem [`AHB_MEM_WORDS];   // expected RAM contents
  logic [IDX_W-1:0]       written_q [$];                // words with known data
  logic [31:0]            lcg_state = 32'd77;

  ahb_subsystem ahb_subsystem_inst (
    .CLK     (CLK),
    .nRST    (nRST),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;   // 40 ns period
  end

  //////////////////////////////
  // helpers

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic stop_with_fail(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_mismatch(input string test, input logic [31:0] exp,
                                 input logic [31:0] act);
    stop_with_fail($sformatf("mismatch %s: expected 0x%08h, actual 0x%08h", test, exp, act));
  endtask

  task automatic add_vec(input string name, input logic wr, input logic held,
                         input logic [31:0] addr, input logic [31:0] wdata,
                         input logic [31:0] rdata, input logic err);
    name_q.push_back(name);
    vec_q.push_back({wr, held, addr, wdata, rdata, err});
  endtask

  // no activity at all for a number of cycles
  task automatic check_idle(input string tag, input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge CLK);
      assert (!mem_rsp.busy && !mem_rsp.done && !mem_rsp.err)
        else stop_with_fail($sformatf("%s: busy, done or err high in idle cycle %0d", tag, i));
    end
  endtask

  // one request, held until done, then dropped on the edge that sees done
  task automatic run_op(input string name, input logic is_write, input logic [31:0] addr,
                        input logic [31:0] wdata, input logic [31:0] exp_rdata,
                        input logic exp_err);
    int                     cyc;
    int                     exp_lat;
    logic                   seen;
    logic                   got_err;
    logic [`AHB_DATA_W-1:0] got_rdata;
    exp_lat   = exp_err ? W + 4 : W + 3;   // error adds the 2nd ERROR cycle
    cyc       = 0;
    seen      = 1'b0;
    got_err   = 1'b0;
    got_rdata = '0;
    @(posedge CLK);
    mem_req.ren   <= ~is_write;
    mem_req.wen   <= is_write;
    mem_req.addr  <= addr;
    mem_req.wdata <= wdata;
    @(posedge CLK);   // master in idle samples the request here
    mem_req.addr  <= ~addr;    // port moves on, transfer must not follow
    mem_req.wdata <= ~wdata;
    while (!seen && cyc < DONE_TIMEOUT) begin
      @(negedge CLK);
      cyc++;
      if (mem_rsp.done) begin
        seen      = 1'b1;
        got_err   = mem_rsp.err;
        got_rdata = mem_rsp.rdata;
      end else begin
        assert (mem_rsp.busy)
          else stop_with_fail($sformatf("%s: busy low before done in cycle %0d", name, cyc));
      end
    end
    if (!seen) begin
      stop_with_fail($sformatf("timeout: no done for %s within %0d cycles", name, cyc));
    end
    @(posedge CLK);   // levels still high on this edge, master is in M_DONE
    mem_req.ren <= 1'b0;
    mem_req.wen <= 1'b0;
    assert (cyc == exp_lat) else report_mismatch({name, " latency"}, exp_lat, cyc);
    assert (got_err == exp_err) else report_mismatch({name, " err"}, 32'(exp_err), 32'(got_err));
    if (!is_write && !exp_err) begin
      assert (got_rdata === exp_rdata) else report_mismatch(name, exp_rdata, got_rdata);
    end
    if (is_write && !exp_err) begin
      model_mem[addr[IDX_W+1:2]] = wdata;
      written_q.push_back(addr[IDX_W+1:2]);
    end
  endtask

  //////////////////////////////
  // main sequence

  initial begin
    logic [IDX_W-1:0] widx;
    int               pick;
    mem_req = '0;
    nRST    = 1'b0;
    //       name               wr    held  addr          wdata         rdata         err
    add_vec("wr_0",            1'b1, 1'b0, 32'h0000_0000, 32'hA5A5_0001, 32'h0,        1'b0);
    add_vec("wr_4",            1'b1, 1'b0, 32'h0000_0004, 32'h1234_5678, 32'h0,        1'b0);
    add_vec("wr_1020",         1'b1, 1'b0, 32'h0000_03FC, 32'hDEAD_BEEF, 32'h0,        1'b0);
    add_vec("rd_0",            1'b0, 1'b0, 32'h0000_0000, 32'h0,         32'hA5A5_0001, 1'b0);
    add_vec("rd_4",            1'b0, 1'b0, 32'h0000_0004, 32'h0,         32'h1234_5678, 1'b0);
    add_vec("rd_1020",         1'b0, 1'b0, 32'h0000_03FC, 32'h0,         32'hDEAD_BEEF, 1'b0);
    add_vec("rd_1024_err",     1'b0, 1'b0, 32'h0000_0400, 32'h0,         32'h0,        1'b1);
    add_vec("wr_2000_err",     1'b1, 1'b0, 32'h0000_2000, 32'hBAD0_BAD0, 32'h0,        1'b1);
    add_vec("rd_6_err",        1'b0, 1'b0, 32'h0000_0006, 32'h0,         32'h0,        1'b1);
    add_vec("wr_2_err",        1'b1, 1'b0, 32'h0000_0002, 32'h5555_AAAA, 32'h0,        1'b1);
    add_vec("rd_0_after_err",  1'b0, 1'b0, 32'h0000_0000, 32'h0,         32'hA5A5_0001, 1'b0);
    add_vec("wr_8_held",       1'b1, 1'b1, 32'h0000_0008, 32'h0F0F_0F0F, 32'h0,        1'b0);
    add_vec("rd_8",            1'b0, 1'b0, 32'h0000_0008, 32'h0,         32'h0F0F_0F0F, 1'b0);
    repeat (16) @(posedge CLK);
    nRST <= 1'b1;
    check_idle("after reset", 8);
    for (int v = 0; v < vec_q.size(); v++) begin
      run_op(name_q[v], vec_q[v].is_write, vec_q[v].addr, vec_q[v].wdata,
             vec_q[v].exp_rdata, vec_q[v].exp_err);
      if (vec_q[v].held) begin
        check_idle({name_q[v], " after done"}, W + 6);   // exactly one done
      end
    end
    // random traffic, even steps write, odd steps read back a known word
    for (int i = 0; i < RAND_OPS; i++) begin
      lcg_state = lcg_next(lcg_state);
      if (i % 2 == 0) begin
        widx      = lcg_state[IDX_W+15:16];
        lcg_state = lcg_next(lcg_state);
        run_op($sformatf("rnd_wr_%0d", i), 1'b1, 32'(widx) << 2, lcg_state, 32'h0, 1'b0);
      end else begin
        pick = int'(lcg_state[31:16]) % written_q.size();
        widx = written_q[pick];
        run_op($sformatf("rnd_rd_%0d", i), 1'b0, 32'(widx) << 2, 32'h0, model_mem[widx], 1'b0);
      end
    end
    if (ahb_subsystem_inst.ahb_assert_inst.fail_cnt == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      stop_with_fail($sformatf("%0d bus protocol assertion failures",
                               ahb_subsystem_inst.ahb_assert_inst.fail_cnt));
    end
  end

endmodule

`default_nettype wire
